//--- src/pipe_consts.svh
`ifndef PIPE_CONSTS_SVH
`define PIPE_CONSTS_SVH

// **********************************************************************
// data memory geometry.
// **********************************************************************
`define PIPE_DMEM_DEPTH 256
`define PIPE_DMEM_AW    8

`define PIPE_PC_W       22

// **********************************************************************
// opcode field of the instruction word.
// **********************************************************************
`define PIPE_OP_NOP     4'h0
`define PIPE_OP_ADD     4'h1
`define PIPE_OP_SUB     4'h2
`define PIPE_OP_AND     4'h3
`define PIPE_OP_OR      4'h4
`define PIPE_OP_XOR     4'h5
`define PIPE_OP_SHL     4'h6
`define PIPE_OP_SHR     4'h7
`define PIPE_OP_LD      4'h8
`define PIPE_OP_ST      4'h9
`define PIPE_OP_BR      4'hA

`endif

//--- src/pipe_pkg.sv
`include "pipe_consts.svh"

package pipe_pkg;

	// **********************************************************************
	// instruction word, read either as an alu or as a memory/branch format.
	// **********************************************************************
	typedef struct packed {
		logic [3:0]  opcode;
		logic [4:0]  dst_reg;
		logic [22:0] unused;
	} instr_alu_t;

	typedef struct packed {
		logic [3:0]         opcode;
		logic [4:0]         dst_reg;
		logic [2:0]         br_cond;    // negative, zero, overflow from msb down.
		logic [3:0]         spare;
		logic signed [15:0] offset;     // byte offset is not used, the index is a word.
	} instr_mem_t;

	typedef union packed {
		instr_alu_t alu;
		instr_mem_t mem;
	} instr_u;

	// same bit order as br_cond so the two can be masked together.
	typedef struct packed {
		logic neg;
		logic zero;
		logic ov;
	} flags_t;

	// **********************************************************************
	// stage bundles.
	// **********************************************************************
	typedef struct packed {
		logic                  valid;
		instr_u                instr;
		logic [31:0]           operand_a;
		logic [31:0]           operand_b;
		logic [31:0]           store_data;
		logic [`PIPE_PC_W-1:0] pc;
		logic [`PIPE_PC_W-1:0] pc_target;
	} id_ex_t;

	typedef struct packed {
		logic                  valid;
		logic [4:0]            dst_reg;
		logic                  use_dst_reg;
		logic                  re;
		logic                  we;
		flags_t                flags;
		logic [2:0]            branch_cond;   // zero unless the instruction is a br.
		logic [31:0]           alu_result;
		logic [31:0]           store_data;
		logic [`PIPE_PC_W-1:0] pc_target;
	} ex_mem_t;

	typedef struct packed {
		logic        valid;
		logic [4:0]  dst_reg;
		logic        use_dst_reg;
		logic [31:0] wb_data;
	} mem_wb_t;

	typedef struct packed {
		logic                  valid;
		logic                  taken;
		logic [`PIPE_PC_W-1:0] target;
	} branch_t;

endpackage

//--- src/ex_alu_stage.sv
`timescale 1ns/1ps
`include "pipe_consts.svh"

module ex_alu_stage (
	input  pipe_pkg::id_ex_t  issue,
	output pipe_pkg::ex_mem_t ex_bundle
);

	logic [3:0]  opcode;
	logic [31:0] op_a;
	logic [31:0] op_b;
	logic [31:0] offset_ext;
	logic [31:0] result;
	logic        is_alu_op;
	logic        ov;

	assign opcode     = issue.instr.alu.opcode;
	assign op_a       = issue.operand_a;
	assign op_b       = issue.operand_b;
	assign offset_ext = {{16{issue.instr.mem.offset[15]}}, issue.instr.mem.offset};

	assign is_alu_op = opcode inside {`PIPE_OP_ADD, `PIPE_OP_SUB, `PIPE_OP_AND, `PIPE_OP_OR,
		`PIPE_OP_XOR, `PIPE_OP_SHL, `PIPE_OP_SHR};

	// **********************************************************************
	// alu.
	// **********************************************************************
	always_comb begin
		case (opcode)
			`PIPE_OP_ADD: result = op_a + op_b;
			`PIPE_OP_SUB,
			`PIPE_OP_BR:  result = op_a - op_b;   // br compares by subtraction.
			`PIPE_OP_AND: result = op_a & op_b;
			`PIPE_OP_OR:  result = op_a | op_b;
			`PIPE_OP_XOR: result = op_a ^ op_b;
			`PIPE_OP_SHL: result = op_a << op_b[4:0];
			`PIPE_OP_SHR: result = op_a >> op_b[4:0];   // logical shift.
			`PIPE_OP_LD,
			`PIPE_OP_ST:  result = op_a + offset_ext;
			default:      result = '0;
		endcase
	end

	// signed overflow, only meaningful for the add and subtract paths.
	always_comb begin
		case (opcode)
			`PIPE_OP_ADD: ov = (op_a[31] == op_b[31]) && (result[31] != op_a[31]);
			`PIPE_OP_SUB,
			`PIPE_OP_BR:  ov = (op_a[31] != op_b[31]) && (result[31] != op_a[31]);
			default:      ov = 1'b0;
		endcase
	end

	// **********************************************************************
	// ex/mem bundle.
	// **********************************************************************
	always_comb begin
		ex_bundle.valid       = issue.valid;
		ex_bundle.dst_reg     = issue.instr.alu.dst_reg;
		ex_bundle.use_dst_reg = issue.valid && (is_alu_op || opcode == `PIPE_OP_LD);
		ex_bundle.re          = issue.valid && (opcode == `PIPE_OP_LD);
		ex_bundle.we          = issue.valid && (opcode == `PIPE_OP_ST);
		ex_bundle.flags.neg   = result[31];
		ex_bundle.flags.zero  = (result == 32'd0);
		ex_bundle.flags.ov    = ov;
		ex_bundle.alu_result  = result;
		ex_bundle.store_data  = issue.store_data;
		ex_bundle.pc_target   = issue.pc_target;
		if (opcode == `PIPE_OP_BR) begin
			ex_bundle.branch_cond = issue.instr.mem.br_cond;
		end else begin
			ex_bundle.branch_cond = 3'b000;
		end
	end

	re_we_exclusive: assert final (!(ex_bundle.re && ex_bundle.we))
		else $error("ex stage raised re and we for the same instruction.");

endmodule

//--- src/ex_mem_pipeline_reg.sv
`timescale 1ns/1ps

module ex_mem_pipeline_reg (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              stall,
	input  logic              hlt,
	input  logic              flush,
	input  pipe_pkg::ex_mem_t ex_bundle,
	output pipe_pkg::ex_mem_t mem_bundle
);

	logic hold;

	assign hold = stall || hlt;

	// **********************************************************************
	// reset, then flush, then stall/halt, then load.
	// **********************************************************************
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_bundle <= '0;
		end else if (flush) begin
			mem_bundle <= '0;   // a bubble has valid, re, we and use_dst_reg low.
		end else if (!hold) begin
			mem_bundle <= ex_bundle;
		end
	end

	// the instruction that was in flight when flush arrived never reaches mem.
	flush_gives_bubble: assert property (
		@(posedge clk) disable iff (!rst_n)
		flush |=> !mem_bundle.valid
	) else $error("ex/mem held a valid instruction after a flush.");

endmodule

//--- src/mem_stage.sv
`timescale 1ns/1ps
`include "pipe_consts.svh"

module mem_stage (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              stall,
	input  logic              hlt,
	input  pipe_pkg::ex_mem_t mem_bundle,
	output pipe_pkg::mem_wb_t wb,
	output pipe_pkg::branch_t branch
);

	logic [31:0]               dmem [`PIPE_DMEM_DEPTH];
	logic [`PIPE_DMEM_AW-1:0]  dmem_idx;
	logic                      advance;
	logic                      br_hit;

	logic                      wb_valid;
	logic [4:0]                wb_dst_reg;
	logic                      wb_use_dst_reg;
	logic [31:0]               wb_data;
	logic                      br_valid;
	logic                      br_taken;
	logic [`PIPE_PC_W-1:0]     br_target;

	assign dmem_idx = mem_bundle.alu_result[`PIPE_DMEM_AW-1:0];
	assign advance  = !stall && !hlt;

	// any set condition bit that matches its flag takes the branch.
	assign br_hit = |(mem_bundle.branch_cond & mem_bundle.flags);

	// **********************************************************************
	// data memory, one word per index.
	// **********************************************************************
	always_ff @(posedge clk) begin
		if (advance && mem_bundle.valid && mem_bundle.we) begin
			dmem[dmem_idx] <= mem_bundle.store_data;
		end
	end

	// load data lands in the output register at the same edge.
	always_ff @(posedge clk) begin
		if (advance) begin
			if (mem_bundle.re) begin
				wb_data <= dmem[dmem_idx];
			end else begin
				wb_data <= mem_bundle.alu_result;
			end
		end
	end

	// **********************************************************************
	// mem/wb and branch result register.
	// **********************************************************************
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_valid       <= 1'b0;
			wb_dst_reg     <= '0;
			wb_use_dst_reg <= 1'b0;
			br_valid       <= 1'b0;
			br_taken       <= 1'b0;
			br_target      <= '0;
		end else if (advance) begin
			wb_valid       <= mem_bundle.valid;
			wb_dst_reg     <= mem_bundle.dst_reg;
			wb_use_dst_reg <= mem_bundle.valid && mem_bundle.use_dst_reg;
			// a br with an empty condition mask resolves like a nop.
			br_valid       <= mem_bundle.valid && (mem_bundle.branch_cond != 3'b000);
			br_taken       <= mem_bundle.valid && br_hit;
			br_target      <= mem_bundle.pc_target;
		end
	end

	assign wb = '{valid: wb_valid, dst_reg: wb_dst_reg, use_dst_reg: wb_use_dst_reg,
		wb_data: wb_data};
	assign branch = '{valid: br_valid, taken: br_taken, target: br_target};

	// decode in ex keeps branches and register writers apart all the way here.
	br_no_reg_write: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(branch.valid && wb.use_dst_reg)
	) else $error("mem stage reported a branch that also writes a register.");

endmodule

//--- src/pipe_backend_top.sv
`timescale 1ns/1ps

module pipe_backend_top (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              stall,
	input  logic              hlt,
	input  logic              flush,
	input  pipe_pkg::id_ex_t  issue,
	output pipe_pkg::mem_wb_t wb,
	output pipe_pkg::branch_t branch
);

	pipe_pkg::ex_mem_t ex_bundle;
	pipe_pkg::ex_mem_t mem_bundle;

	// **********************************************************************
	// execute, ex/mem register, memory.
	// **********************************************************************
	ex_alu_stage ex_alu_stage_i (
		.issue     (issue),
		.ex_bundle (ex_bundle)
	);

	ex_mem_pipeline_reg ex_mem_pipeline_reg_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.stall      (stall),
		.hlt        (hlt),
		.flush      (flush),
		.ex_bundle  (ex_bundle),
		.mem_bundle (mem_bundle)
	);

	mem_stage mem_stage_i (   // flush does not reach the memory stage.
		.clk        (clk),
		.rst_n      (rst_n),
		.stall      (stall),
		.hlt        (hlt),
		.mem_bundle (mem_bundle),
		.wb         (wb),
		.branch     (branch)
	);

endmodule

//--- tests/pipe_backend_tb.sv
`timescale 1ns/1ps
`include "pipe_consts.svh"

module pipe_backend_tb;

	localparam int RESET_CYCLES  = 16;
	localparam int RESET_TIMEOUT = 64;
	localparam int DRAIN_TIMEOUT = 16;
	localparam int BUBBLE        = -1;   // ex/mem holds no instruction.

	logic              clk;
	logic              rst_n;
	logic              stall;
	logic              hlt;
	logic              flush;
	pipe_pkg::id_ex_t  issue;
	pipe_pkg::mem_wb_t wb;
	pipe_pkg::branch_t branch;

	string             vec_name [$];
	pipe_pkg::id_ex_t  vec_issue [$];
	logic [2:0]        vec_ctrl [$];   // stall, hlt and flush from msb down.
	pipe_pkg::mem_wb_t vec_wb [$];
	pipe_pkg::branch_t vec_br [$];
	logic              vec_expect [$];

	int exm_q [$];   // vector index held by ex/mem, one entry deep.
	int in_mem;      // vector index whose result mem currently shows.
	int due;
	int seed;

	pipe_backend_top pipe_backend_top_i (
		.clk    (clk),
		.rst_n  (rst_n),
		.stall  (stall),
		.hlt    (hlt),
		.flush  (flush),
		.issue  (issue),
		.wb     (wb),
		.branch (branch)
	);

	always #10 clk = ~clk;

	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

	task automatic abort_run(input string why);
		$display("*** FAILED ***");
		$fatal(1, "%s", why);
	endtask

	// **********************************************************************
	// result compares, data only where a register write is expected.
	// **********************************************************************
	task automatic check_wb(input string name, input pipe_pkg::mem_wb_t exp,
		input pipe_pkg::mem_wb_t act);
		logic bad;
		bad = (act.valid !== exp.valid) || (act.use_dst_reg !== exp.use_dst_reg);
		if (exp.use_dst_reg) begin
			bad = bad || (act.dst_reg !== exp.dst_reg) || (act.wb_data !== exp.wb_data);
		end
		if (bad) begin
			$write("FAILED %s wb expected v=%b use=%b dst=%0d data=%h", name, exp.valid,
				exp.use_dst_reg, exp.dst_reg, exp.wb_data);
			$display(" actual v=%b use=%b dst=%0d data=%h", act.valid, act.use_dst_reg,
				act.dst_reg, act.wb_data);
			abort_run("write-back result mismatch.");
		end
	endtask

	task automatic check_branch(input string name, input pipe_pkg::branch_t exp,
		input pipe_pkg::branch_t act);
		logic bad;
		bad = (act.valid !== exp.valid) || (act.taken !== exp.taken);
		if (exp.valid) begin
			bad = bad || (act.target !== exp.target);
		end
		if (bad) begin
			$write("FAILED %s branch expected v=%b taken=%b target=%h", name, exp.valid,
				exp.taken, exp.target);
			$display(" actual v=%b taken=%b target=%h", act.valid, act.taken, act.target);
			abort_run("branch result mismatch.");
		end
	endtask

	task automatic load_vectors();
		int fd;
		int n;
		string line;
		string name;
		logic [31:0] f [18];
		pipe_pkg::id_ex_t iss;
		pipe_pkg::mem_wb_t ew;
		pipe_pkg::branch_t eb;
		fd = $fopen("tests/pipe_backend_golden.txt", "r");
		if (fd == 0) begin
			abort_run("golden vector file could not be opened.");
		end
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			if (n == 0 || line.len() < 2 || line[0] == "#") continue;
			n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h", name,
				f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11],
				f[12], f[13], f[14], f[15], f[16], f[17]);
			if (n != 19) begin
				abort_run("a golden vector line has the wrong number of columns.");
			end
			iss.valid = f[0][0];
			iss.instr = f[1];
			iss.operand_a = f[2];
			iss.operand_b = f[3];
			iss.store_data = f[4];
			iss.pc = f[5][`PIPE_PC_W-1:0];
			iss.pc_target = f[6][`PIPE_PC_W-1:0];
			ew = '{valid: f[10][0], dst_reg: f[11][4:0], use_dst_reg: f[12][0], wb_data: f[13]};
			eb = '{valid: f[14][0], taken: f[15][0], target: f[16][`PIPE_PC_W-1:0]};
			vec_name.push_back(name);
			vec_issue.push_back(iss);
			vec_ctrl.push_back({f[7][0], f[8][0], f[9][0]});
			vec_wb.push_back(ew);
			vec_br.push_back(eb);
			vec_expect.push_back(f[17][0]);
		end
		$fclose(fd);
	endtask

	// **********************************************************************
	// one clock: drive at the falling edge, model ex/mem, check one edge later.
	// **********************************************************************
	task automatic run_cycle(input int idx);
		pipe_pkg::id_ex_t nxt;
		logic [2:0] ctrl;
		int entered;
		string tag;
		nxt = '0;
		ctrl = 3'b000;
		tag = "drain";
		if (idx >= 0) begin
			nxt = vec_issue[idx];
			ctrl = vec_ctrl[idx];
			tag = vec_name[idx];
		end
		if (nxt.valid && nxt.instr.alu.opcode == `PIPE_OP_NOP) begin
			nxt.operand_a = $random(seed);   // nop operands never reach a result.
			nxt.operand_b = $random(seed);
		end
		issue = nxt;
		stall = ctrl[2];
		hlt = ctrl[1];
		flush = ctrl[0];
		@(posedge clk);
		entered = (idx >= 0 && vec_expect[idx]) ? idx : BUBBLE;
		if (ctrl[2] || ctrl[1]) begin
			due = in_mem;   // mem keeps showing the result it already holds.
			if (ctrl[0]) exm_q[0] = BUBBLE;   // flush still empties a held ex/mem.
		end else begin
			due = exm_q.pop_front();
			exm_q.push_back(ctrl[0] ? BUBBLE : entered);
		end
		in_mem = due;
		@(negedge clk);
		if (due >= 0) begin
			check_wb(vec_name[due], vec_wb[due], wb);
			check_branch(vec_name[due], vec_br[due], branch);
		end else begin
			check_wb({"bubble at ", tag}, '0, wb);
			check_branch({"bubble at ", tag}, '0, branch);
		end
	endtask

	initial begin
		int cycles;
		clk = 1'b0;
		stall = 1'b0;
		hlt = 1'b0;
		flush = 1'b0;
		issue = '0;
		seed = 61;
		load_vectors();
		exm_q.push_back(BUBBLE);
		in_mem = BUBBLE;
		cycles = 0;
		while (rst_n !== 1'b1) begin
			@(negedge clk);
			check_wb("in_reset", '0, wb);
			check_branch("in_reset", '0, branch);
			cycles++;
			if (cycles > RESET_TIMEOUT) begin
				$display("timed out waiting for reset to be released.");
				abort_run("reset release wait expired.");
			end
		end
		check_wb("after_reset", '0, wb);
		check_branch("after_reset", '0, branch);
		foreach (vec_issue[i]) begin
			run_cycle(i);
		end
		cycles = 0;
		while (exm_q[0] != BUBBLE) begin
			run_cycle(-1);
			cycles++;
			if (cycles > DRAIN_TIMEOUT) begin
				$display("timed out draining the expected results.");
				abort_run("final drain wait expired.");
			end
		end
		run_cycle(-1);
		$display("*** PASSED ***");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+src
src/pipe_pkg.sv
src/ex_alu_stage.sv
src/ex_mem_pipeline_reg.sv
src/mem_stage.sv
src/pipe_backend_top.sv
tests/pipe_backend_tb.sv

//--- tests/pipe_backend_golden.txt
# name valid instr operand_a operand_b store_data pc pc_target stall hlt flush
# then wb_valid dst_reg use_dst_reg wb_data br_valid br_taken br_target result_expected
nop_warmup    1 00000000 00000000 00000000 00000000 000000 000000 0 0 0 1 00 0 00000000 0 0 000000 1
add_basic     1 10800000 00000005 00000007 00000000 000004 000000 0 0 0 1 01 1 0000000c 0 0 000000 1
sub_basic     1 21000000 0000000a 00000003 00000000 000008 000000 0 0 0 1 02 1 00000007 0 0 000000 1
sub_neg       1 23000000 00000003 00000005 00000000 00000c 000000 0 0 0 1 06 1 fffffffe 0 0 000000 1
and_basic     1 31800000 f0f0f0f0 0ff00ff0 00000000 000010 000000 0 0 0 1 03 1 00f000f0 0 0 000000 1
or_basic      1 42000000 f0f00000 0000f0f0 00000000 000014 000000 0 0 0 1 04 1 f0f0f0f0 0 0 000000 1
xor_basic     1 52800000 aaaa5555 ffff0000 00000000 000018 000000 0 0 0 1 05 1 55555555 0 0 000000 1
shl_basic     1 63000000 00000003 00000124 00000000 00001c 000000 0 0 0 1 06 1 00000030 0 0 000000 1
shr_basic     1 73800000 80000000 0000001f 00000000 000020 000000 0 0 0 1 07 1 00000001 0 0 000000 1
add_ovf_pos   1 14000000 7fffffff 00000001 00000000 000024 000000 0 0 0 1 08 1 80000000 0 0 000000 1
add_ovf_neg   1 13800000 80000000 80000000 00000000 000028 000000 0 0 0 1 07 1 00000000 0 0 000000 1
sub_ovf_lim   1 24800000 80000000 00000001 00000000 00002c 000000 0 0 0 1 09 1 7fffffff 0 0 000000 1
nop_fill_a    1 00000000 00000000 00000000 00000000 000030 000000 0 0 0 1 00 0 00000000 0 0 000000 1
st_word       1 90000010 00000020 00000000 deadbeef 000034 000000 0 0 0 1 00 0 00000000 0 0 000000 1
ld_word       1 85000010 00000020 00000000 00000000 000038 000000 0 0 0 1 0a 1 deadbeef 0 0 000000 1
st_neg_off    1 9000fffc 00000002 00000000 12345678 00003c 000000 0 0 0 1 00 0 00000000 0 0 000000 1
ld_neg_off    1 8080fffc 00000102 00000000 00000000 000040 000000 0 0 0 1 01 1 12345678 0 0 000000 1
br_neg_taken  1 a0400000 00000001 00000002 00000000 000044 000200 0 0 0 1 00 0 00000000 1 1 000200 1
br_zero_taken 1 a0200000 00000005 00000005 00000000 000048 000280 0 0 0 1 00 0 00000000 1 1 000280 1
br_ov_taken   1 a0100000 80000000 00000001 00000000 00004c 0002c0 0 0 0 1 00 0 00000000 1 1 0002c0 1
br_ov_near    1 a0100000 7fffffff ffffffff 00000000 000050 000380 0 0 0 1 00 0 00000000 1 1 000380 1
br_zero_miss  1 a0200000 00000005 00000003 00000000 000054 000300 0 0 0 1 00 0 00000000 1 0 000300 1
br_mixed_miss 1 a0500000 00000003 00000001 00000000 000058 000340 0 0 0 1 00 0 00000000 1 0 000340 1
br_no_cond    1 a0000000 00000005 00000005 00000000 00005c 0003c0 0 0 0 1 00 0 00000000 0 0 000000 1
idle_gap      0 00000000 00000000 00000000 00000000 000060 000000 0 0 0 0 00 0 00000000 0 0 000000 0
nop_fill_b    1 00000000 00000000 00000000 00000000 000064 000000 0 0 0 1 00 0 00000000 0 0 000000 1
st_stall      1 90000000 00000040 00000000 cafef00d 000068 000000 0 0 0 1 00 0 00000000 0 0 000000 1
ld_stalled    1 81800000 00000040 00000000 00000000 00006c 000000 1 0 0 0 00 0 00000000 0 0 000000 0
ld_halted     1 81800000 00000040 00000000 00000000 00006c 000000 0 1 0 0 00 0 00000000 0 0 000000 0
ld_released   1 81800000 00000040 00000000 00000000 00006c 000000 0 0 0 1 03 1 cafef00d 0 0 000000 1
add_pre_flush 1 12000000 00000001 00000002 00000000 000070 000000 0 0 0 1 04 1 00000003 0 0 000000 1
st_flushed    1 90000000 00000040 00000000 0badf00d 000074 000000 0 0 1 0 00 0 00000000 0 0 000000 0
add_flushed   1 12800000 00000001 00000001 00000000 000078 000000 0 0 1 0 00 0 00000000 0 0 000000 0
ld_post_flush 1 82800000 00000040 00000000 00000000 00007c 000000 0 0 0 1 05 1 cafef00d 0 0 000000 1
nop_fill_c    1 00000000 00000000 00000000 00000000 000080 000000 0 0 0 1 00 0 00000000 0 0 000000 1
